//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int isa_width = 32;

    typedef logic [isa_width-1:0] word_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [5:0]           opcode_t;
    typedef logic [5:0]           funct_t;
    typedef logic [15:0]          imm_t;

    // primary opcodes, bits 31:26
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_addi  = 6'h08;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    // r-type funct, bits 5:0
    localparam funct_t fn_add = 6'h20;
    localparam funct_t fn_sub = 6'h22;
    localparam funct_t fn_and = 6'h24;
    localparam funct_t fn_or  = 6'h25;
    localparam funct_t fn_slt = 6'h2a;

endpackage

`default_nettype wire

//--- rtl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    // EX operand source
    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // data bus master states
    typedef enum logic [1:0] {
        bus_idle,
        bus_wait,
        bus_done
    } bus_state_t;

endpackage

`default_nettype wire

//--- rtl/decode_unit.sv
`default_nettype none

module decode_unit (
    input  wire isa_pkg::word_t instr,
    output isa_pkg::reg_idx_t   rs_idx,
    output isa_pkg::reg_idx_t   rt_idx,
    output isa_pkg::reg_idx_t   dest_idx,
    output isa_pkg::word_t      imm_ext,
    output pipe_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                reads_rt
);

    isa_pkg::opcode_t  opcode;
    isa_pkg::funct_t   funct;
    isa_pkg::imm_t     imm;
    isa_pkg::reg_idx_t rd_idx;

    assign opcode  = instr[31:26];
    assign rs_idx  = instr[25:21];
    assign rt_idx  = instr[20:16];
    assign rd_idx  = instr[15:11];
    assign imm     = instr[15:0];
    assign funct   = instr[5:0];
    assign imm_ext = {{(isa_pkg::isa_width-16){imm[15]}}, imm};

    always_comb begin
        alu_op    = pipe_pkg::alu_add;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reads_rt  = 1'b0;
        dest_idx  = rt_idx;
        case (opcode)
            isa_pkg::op_rtype: begin
                dest_idx  = rd_idx;
                reads_rt  = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    isa_pkg::fn_add: alu_op = pipe_pkg::alu_add;
                    isa_pkg::fn_sub: alu_op = pipe_pkg::alu_sub;
                    isa_pkg::fn_and: alu_op = pipe_pkg::alu_and;
                    isa_pkg::fn_or:  alu_op = pipe_pkg::alu_or;
                    isa_pkg::fn_slt: alu_op = pipe_pkg::alu_slt;
                    default:         reg_write = 1'b0;
                endcase
            end
            isa_pkg::op_addi: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            isa_pkg::op_lw: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            isa_pkg::op_sw: begin
                // address from rs + imm, data from rt
                use_imm   = 1'b1;
                mem_write = 1'b1;
                reads_rt  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`default_nettype none

module register_file (
    input  wire                    clk_raw,
    input  wire                    rst_n,
    input  wire isa_pkg::reg_idx_t rd_idx_a,
    input  wire isa_pkg::reg_idx_t rd_idx_b,
    output isa_pkg::word_t         rd_data_a,
    output isa_pkg::word_t         rd_data_b,
    input  wire                    wr_en,
    input  wire isa_pkg::reg_idx_t wr_idx,
    input  wire isa_pkg::word_t    wr_data
);

    isa_pkg::word_t regs [1:31];

    // r0 is constant, a same-cycle write shows through
    function automatic isa_pkg::word_t read_port(input isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en && wr_idx == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
    end

    always_ff @(posedge clk_raw) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/forwarding_unit.sv
`default_nettype none

module forwarding_unit (
    input  wire isa_pkg::reg_idx_t ex_rs,
    input  wire isa_pkg::reg_idx_t ex_rt,
    input  wire isa_pkg::reg_idx_t mem_dest,
    input  wire isa_pkg::reg_idx_t wb_dest,
    input  wire                    mem_reg_write,
    input  wire                    wb_reg_write,
    output pipe_pkg::fwd_sel_t     sel_a,
    output pipe_pkg::fwd_sel_t     sel_b
);

    // younger result in MEM wins over WB
    function automatic pipe_pkg::fwd_sel_t pick(input isa_pkg::reg_idx_t src);
        if (src == '0) begin
            return pipe_pkg::fwd_none;
        end else if (mem_reg_write && mem_dest == src) begin
            return pipe_pkg::fwd_mem;
        end else if (wb_reg_write && wb_dest == src) begin
            return pipe_pkg::fwd_wb;
        end
        return pipe_pkg::fwd_none;
    endfunction

    // sel_b also steers the sw data
    always_comb begin
        sel_a = pick(ex_rs);
        sel_b = pick(ex_rt);
    end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input  wire isa_pkg::reg_idx_t id_rs,
    input  wire isa_pkg::reg_idx_t id_rt,
    input  wire                    id_reads_rt,
    input  wire                    ex_mem_read,
    input  wire isa_pkg::reg_idx_t ex_dest,
    input  wire                    mem_busy,
    output logic                   hold_front,
    output logic                   bubble_ex,
    output logic                   freeze_mem,
    output logic                   instr_ready
);

    logic load_use;

    // lw result is not ready until WB, dependent waits one cycle
    assign load_use = ex_mem_read && ex_dest != '0 &&
                      (ex_dest == id_rs || (id_reads_rt && ex_dest == id_rt));

    // a pending bus access stops everything up to MEM
    assign freeze_mem  = mem_busy;
    assign hold_front  = mem_busy || load_use;
    assign bubble_ex   = load_use && !mem_busy;
    assign instr_ready = !hold_front;

endmodule

`default_nettype wire

//--- rtl/alu_stage.sv
`default_nettype none

module alu_stage (
    input  wire pipe_pkg::alu_op_t  alu_op,
    input  wire                     use_imm,
    input  wire isa_pkg::word_t     rs_val,
    input  wire isa_pkg::word_t     rt_val,
    input  wire isa_pkg::word_t     imm_ext,
    input  wire isa_pkg::word_t     mem_fwd,
    input  wire isa_pkg::word_t     wb_fwd,
    input  wire pipe_pkg::fwd_sel_t sel_a,
    input  wire pipe_pkg::fwd_sel_t sel_b,
    output isa_pkg::word_t          result,
    output isa_pkg::word_t          store_data
);

    isa_pkg::word_t op_a;
    isa_pkg::word_t op_b;
    isa_pkg::word_t rt_fwd;

    function automatic isa_pkg::word_t fwd_mux(input pipe_pkg::fwd_sel_t sel,
                                               input isa_pkg::word_t     reg_val,
                                               input isa_pkg::word_t     mem_val,
                                               input isa_pkg::word_t     wb_val);
        case (sel)
            pipe_pkg::fwd_mem: return mem_val;
            pipe_pkg::fwd_wb:  return wb_val;
            default:           return reg_val;
        endcase
    endfunction

    assign op_a       = fwd_mux(sel_a, rs_val, mem_fwd, wb_fwd);
    assign rt_fwd     = fwd_mux(sel_b, rt_val, mem_fwd, wb_fwd);
    assign op_b       = use_imm ? imm_ext : rt_fwd;
    assign store_data = rt_fwd;

    always_comb begin
        case (alu_op)
            pipe_pkg::alu_add: result = op_a + op_b;
            pipe_pkg::alu_sub: result = op_a - op_b;
            pipe_pkg::alu_and: result = op_a & op_b;
            pipe_pkg::alu_or:  result = op_a | op_b;
            pipe_pkg::alu_slt: begin
                // signed compare, 1 or 0
                result = {{(isa_pkg::isa_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/wb_data_port.sv
`default_nettype none

module wb_data_port (
    input  wire                 clk_raw,
    input  wire                 rst_n,
    input  wire                 mem_read,
    input  wire                 mem_write,
    input  wire isa_pkg::word_t addr,
    input  wire isa_pkg::word_t store_data,
    output isa_pkg::word_t      load_data,
    output logic                mem_busy,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output isa_pkg::word_t      wb_adr,
    output isa_pkg::word_t      wb_dat_o,
    input  wire isa_pkg::word_t wb_dat_i,
    input  wire                 wb_ack
);

    pipe_pkg::bus_state_t state;
    logic                 launch;

    assign launch   = (state == pipe_pkg::bus_idle) && (mem_read || mem_write);
    assign mem_busy = launch || (state == pipe_pkg::bus_wait);
    assign wb_cyc   = (state == pipe_pkg::bus_wait);
    assign wb_stb   = wb_cyc;

    always_ff @(posedge clk_raw) begin
        if (!rst_n) begin
            state <= pipe_pkg::bus_idle;
            wb_we <= 1'b0;
        end else begin
            case (state)
                pipe_pkg::bus_idle: begin
                    if (launch) begin
                        state <= pipe_pkg::bus_wait;
                        wb_we <= mem_write;
                    end
                end
                pipe_pkg::bus_wait: begin
                    if (wb_ack) begin
                        state <= pipe_pkg::bus_done;
                        wb_we <= 1'b0;
                    end
                end
                // pipeline moves on this cycle, MEM holds a new instruction after
                pipe_pkg::bus_done: state <= pipe_pkg::bus_idle;
                default:            state <= pipe_pkg::bus_idle;
            endcase
        end
    end

    // address and write data stay fixed for the whole cycle
    always_ff @(posedge clk_raw) begin
        if (launch) begin
            wb_adr   <= addr;
            wb_dat_o <= store_data;
        end
        if (state == pipe_pkg::bus_wait && wb_ack) begin
            load_data <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mips_pipeline.sv
`default_nettype none

module mips_pipeline (
    input  wire                 clk_raw,
    input  wire                 rst_n,
    input  wire isa_pkg::word_t instr,
    input  wire                 instr_valid,
    output logic                instr_ready,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic                wb_we,
    output isa_pkg::word_t      wb_adr,
    output isa_pkg::word_t      wb_dat_o,
    input  wire isa_pkg::word_t wb_dat_i,
    input  wire                 wb_ack
);

    logic                if_id_valid;
    isa_pkg::word_t      if_id_instr;

    isa_pkg::reg_idx_t   dec_rs, dec_rt, dec_dest;
    isa_pkg::word_t      dec_imm, rf_data_a, rf_data_b;
    pipe_pkg::alu_op_t   dec_alu_op;
    logic                dec_use_imm, dec_reg_write, dec_mem_read, dec_mem_write, dec_reads_rt;

    logic                id_ex_valid, id_ex_use_imm, id_ex_reg_write;
    logic                id_ex_mem_read, id_ex_mem_write;
    pipe_pkg::alu_op_t   id_ex_alu_op;
    isa_pkg::reg_idx_t   id_ex_rs, id_ex_rt, id_ex_dest;
    isa_pkg::word_t      id_ex_rs_val, id_ex_rt_val, id_ex_imm;

    pipe_pkg::fwd_sel_t  sel_a, sel_b;
    isa_pkg::word_t      alu_result, alu_store_data;

    logic                ex_mem_valid, ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
    isa_pkg::reg_idx_t   ex_mem_dest;
    isa_pkg::word_t      ex_mem_alu, ex_mem_store_data, load_data;

    logic                mem_wb_valid, mem_wb_reg_write;
    isa_pkg::reg_idx_t   mem_wb_dest;
    isa_pkg::word_t      mem_wb_value;

    logic                mem_busy, hold_front, bubble_ex, freeze_mem;

    decode_unit decode_i (
        .instr(if_id_instr), .rs_idx(dec_rs), .rt_idx(dec_rt), .dest_idx(dec_dest),
        .imm_ext(dec_imm), .alu_op(dec_alu_op), .use_imm(dec_use_imm),
        .reg_write(dec_reg_write), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
        .reads_rt(dec_reads_rt)
    );

    register_file regfile_i (
        .clk_raw(clk_raw), .rst_n(rst_n), .rd_idx_a(dec_rs), .rd_idx_b(dec_rt),
        .rd_data_a(rf_data_a), .rd_data_b(rf_data_b),
        .wr_en(mem_wb_valid && mem_wb_reg_write), .wr_idx(mem_wb_dest), .wr_data(mem_wb_value)
    );

    hazard_unit hazard_i (
        .id_rs(dec_rs), .id_rt(dec_rt), .id_reads_rt(dec_reads_rt),
        .ex_mem_read(id_ex_valid && id_ex_mem_read), .ex_dest(id_ex_dest),
        .mem_busy(mem_busy), .hold_front(hold_front), .bubble_ex(bubble_ex),
        .freeze_mem(freeze_mem), .instr_ready(instr_ready)
    );

    forwarding_unit forward_i (
        .ex_rs(id_ex_rs), .ex_rt(id_ex_rt), .mem_dest(ex_mem_dest), .wb_dest(mem_wb_dest),
        .mem_reg_write(ex_mem_valid && ex_mem_reg_write),
        .wb_reg_write(mem_wb_valid && mem_wb_reg_write), .sel_a(sel_a), .sel_b(sel_b)
    );

    alu_stage alu_i (
        .alu_op(id_ex_alu_op), .use_imm(id_ex_use_imm), .rs_val(id_ex_rs_val),
        .rt_val(id_ex_rt_val), .imm_ext(id_ex_imm), .mem_fwd(ex_mem_alu),
        .wb_fwd(mem_wb_value), .sel_a(sel_a), .sel_b(sel_b), .result(alu_result),
        .store_data(alu_store_data)
    );

    wb_data_port data_port_i (
        .clk_raw(clk_raw), .rst_n(rst_n), .mem_read(ex_mem_valid && ex_mem_mem_read),
        .mem_write(ex_mem_valid && ex_mem_mem_write), .addr(ex_mem_alu),
        .store_data(ex_mem_store_data), .load_data(load_data), .mem_busy(mem_busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    always_ff @(posedge clk_raw) begin
        if (!rst_n) begin
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
        end else begin
            if (!hold_front) begin
                if_id_valid <= instr_valid;
            end
            if (!freeze_mem) begin
                id_ex_valid  <= if_id_valid && !bubble_ex;
                ex_mem_valid <= id_ex_valid;
            end
            mem_wb_valid <= ex_mem_valid && !freeze_mem;
        end
    end

    // bubbles carry a zero word so their indices never match a hazard
    always_ff @(posedge clk_raw) begin
        if (!hold_front) begin
            if_id_instr <= instr_valid ? instr : '0;
        end
    end

    always_ff @(posedge clk_raw) begin
        if (!freeze_mem) begin
            id_ex_alu_op    <= dec_alu_op;
            id_ex_use_imm   <= dec_use_imm;
            id_ex_reg_write <= dec_reg_write;
            id_ex_mem_read  <= dec_mem_read;
            id_ex_mem_write <= dec_mem_write;
            id_ex_rs        <= dec_rs;
            id_ex_rt        <= dec_rt;
            id_ex_dest      <= dec_dest;
            id_ex_rs_val    <= rf_data_a;
            id_ex_rt_val    <= rf_data_b;
            id_ex_imm       <= dec_imm;
        end else begin
            // WB drains while frozen, keep its value for the waiting EX op
            if (sel_a == pipe_pkg::fwd_wb) begin
                id_ex_rs_val <= mem_wb_value;
            end
            if (sel_b == pipe_pkg::fwd_wb) begin
                id_ex_rt_val <= mem_wb_value;
            end
        end
    end

    always_ff @(posedge clk_raw) begin
        if (!freeze_mem) begin
            ex_mem_reg_write  <= id_ex_reg_write;
            ex_mem_mem_read   <= id_ex_mem_read;
            ex_mem_mem_write  <= id_ex_mem_write;
            ex_mem_dest       <= id_ex_dest;
            ex_mem_alu        <= alu_result;
            ex_mem_store_data <= alu_store_data;
        end
        mem_wb_reg_write <= ex_mem_reg_write;
        mem_wb_dest      <= ex_mem_dest;
        // write-back value
        mem_wb_value     <= ex_mem_mem_read ? load_data : ex_mem_alu;
    end

endmodule

`default_nettype wire

//--- verif/mips_pipeline_properties.sv
`default_nettype none

module mips_pipeline_properties (
    input wire                 clk_raw,
    input wire                 rst_n,
    input wire                 instr_ready,
    input wire                 mem_busy,
    input wire                 wb_cyc,
    input wire                 wb_stb,
    input wire                 wb_we,
    input wire isa_pkg::word_t wb_adr,
    input wire isa_pkg::word_t wb_dat_o,
    input wire                 wb_ack
);

    cyc_matches_stb: assert property (@(posedge clk_raw) disable iff (!rst_n)
        wb_cyc == wb_stb)
        else $error("wb_cyc and wb_stb differ");

    // request fields frozen until the ack edge
    request_held: assert property (@(posedge clk_raw) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o))
        else $error("bus request changed or dropped before ack");

    drop_after_ack: assert property (@(posedge clk_raw) disable iff (!rst_n)
        wb_stb && wb_ack |=> !wb_stb)
        else $error("wb_stb still high in the cycle after ack");

    we_inside_cycle: assert property (@(posedge clk_raw) disable iff (!rst_n)
        !wb_stb |-> !wb_we)
        else $error("wb_we high outside a bus cycle");

    // load-use stall alone lasts one cycle, longer holds come from the bus
    load_use_one_cycle: assert property (@(posedge clk_raw) disable iff (!rst_n)
        !instr_ready && !mem_busy |=> instr_ready || mem_busy)
        else $error("fetch stalled more than one cycle without a bus access");

    idle_after_reset: assert property (@(posedge clk_raw)
        !rst_n |=> !wb_cyc && !wb_we && instr_ready)
        else $error("bus not idle or fetch not ready after reset");

endmodule

`default_nettype wire

//--- verif/tb_mips_pipeline.sv
`default_nettype none

module tb_mips_pipeline;

    localparam int reset_cycles = 8;
    localparam int prog_len     = 53;

    logic           clk_raw = 1'b0;
    logic           rst_n;
    isa_pkg::word_t instr;
    logic           instr_valid;
    logic           instr_ready;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    isa_pkg::word_t wb_adr;
    isa_pkg::word_t wb_dat_o;
    isa_pkg::word_t wb_dat_i;
    logic           wb_ack;

    isa_pkg::word_t mem [256];
    isa_pkg::word_t ref_mem [256];
    isa_pkg::word_t ref_regs [32];
    isa_pkg::word_t exp_adr [$];
    isa_pkg::word_t exp_dat [$];
    logic [15:0]    lfsr = 16'd28953;
    logic           use_gaps = 1'b0;
    int             mem_ops = 0;
    int             bus_cycles = 0;

    mips_pipeline dut_i (
        .clk_raw(clk_raw), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
        .instr_ready(instr_ready), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    bind mips_pipeline mips_pipeline_properties props_i (
        .clk_raw(clk_raw), .rst_n(rst_n), .instr_ready(instr_ready), .mem_busy(mem_busy),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
    );

    always #2 clk_raw = ~clk_raw;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = (val << 1) | int'(lfsr[0]);
        end
        return val;
    endfunction

    function automatic isa_pkg::word_t fill_word(input int idx);
        return isa_pkg::word_t'(idx) * 32'h0104_0811 + 32'h3c00_0000;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input isa_pkg::word_t exp,
                                   input isa_pkg::word_t act);
        stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
    endtask

    // caller sits on a falling edge, returns on one
    task automatic issue(input isa_pkg::word_t word);
        instr       = word;
        instr_valid = 1'b1;
        while (!instr_ready) begin
            @(negedge clk_raw);
        end
        @(negedge clk_raw);
        instr_valid = 1'b0;
        if (use_gaps) begin
            repeat (rand_bits(2)) @(negedge clk_raw);
        end
    endtask

    task automatic set_reg(input int rd, input isa_pkg::word_t val);
        if (rd != 0) begin
            ref_regs[rd[4:0]] = val;
        end
    endtask

    task automatic run_r(input isa_pkg::funct_t fn, input int rd, input int rs, input int rt);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t res;
        a = ref_regs[rs[4:0]];
        b = ref_regs[rt[4:0]];
        case (fn)
            isa_pkg::fn_add: res = a + b;
            isa_pkg::fn_sub: res = a - b;
            isa_pkg::fn_and: res = a & b;
            isa_pkg::fn_or:  res = a | b;
            default:         res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        set_reg(rd, res);
        issue({isa_pkg::op_rtype, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn});
    endtask

    task automatic run_addi(input int rt, input int rs, input int imm);
        set_reg(rt, ref_regs[rs[4:0]] + isa_pkg::word_t'(imm));
        issue({isa_pkg::op_addi, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    task automatic run_lw(input int rt, input int rs, input int imm);
        isa_pkg::word_t addr;
        addr = ref_regs[rs[4:0]] + isa_pkg::word_t'(imm);
        set_reg(rt, ref_mem[addr[9:2]]);
        mem_ops++;
        issue({isa_pkg::op_lw, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    task automatic run_sw(input int rt, input int rs, input int imm);
        isa_pkg::word_t addr;
        addr = ref_regs[rs[4:0]] + isa_pkg::word_t'(imm);
        ref_mem[addr[9:2]] = ref_regs[rt[4:0]];
        exp_adr.push_back(addr);
        exp_dat.push_back(ref_regs[rt[4:0]]);
        mem_ops++;
        issue({isa_pkg::op_sw, rs[4:0], rt[4:0], imm[15:0]});
    endtask

    task automatic check_store(input isa_pkg::word_t adr, input isa_pkg::word_t dat);
        if (exp_adr.size() == 0) begin
            stop_run("bus write seen with no outstanding sw to match it");
        end else begin
            assert (adr == exp_adr[0]) else report_mismatch("wb_adr", exp_adr[0], adr);
            assert (dat == exp_dat[0]) else report_mismatch("wb_dat_o", exp_dat[0], dat);
            void'(exp_adr.pop_front());
            void'(exp_dat.pop_front());
        end
    endtask

    task automatic run_program();
        // negative immediates
        run_addi(1, 0, -5);
        run_addi(2, 1, 300);
        run_addi(3, 2, -32768);
        run_addi(4, 0, 32767);
        // back-to-back chain through MEM and WB
        run_r(isa_pkg::fn_add, 5, 4, 3);
        run_r(isa_pkg::fn_sub, 6, 5, 1);
        run_r(isa_pkg::fn_and, 7, 6, 5);
        run_r(isa_pkg::fn_or, 8, 7, 2);
        run_r(isa_pkg::fn_slt, 9, 8, 1);
        run_r(isa_pkg::fn_slt, 10, 1, 8);
        run_addi(11, 0, 256);
        for (int i = 1; i <= 10; i++) begin
            run_sw(i, 11, 4 * i);
        end
        // load-use on rs, then on the store data
        run_lw(12, 11, 64);
        run_r(isa_pkg::fn_add, 13, 12, 5);
        run_sw(13, 11, 68);
        run_lw(14, 11, 8);
        run_sw(14, 11, 72);
        run_addi(0, 0, 123);
        run_r(isa_pkg::fn_add, 0, 1, 2);
        run_sw(0, 11, 76);
        use_gaps = 1'b1;
        for (int i = 0; i < 6; i++) begin
            run_addi(16, 16, -7 * i - 1);
            run_lw(17, 11, 4 * i + 128);
            run_r(isa_pkg::fn_sub, 18, 17, 16);
            run_sw(18, 11, 4 * i + 160);
        end
    endtask

    initial begin : bus_responder
        logic           we;
        isa_pkg::word_t adr;
        isa_pkg::word_t dat;
        forever begin
            @(negedge clk_raw);
            if (wb_stb) begin
                repeat (rand_bits(2)) @(negedge clk_raw);
                we       = wb_we;
                adr      = wb_adr;
                dat      = wb_dat_o;
                wb_dat_i = mem[adr[9:2]];
                wb_ack   = 1'b1;
                @(posedge clk_raw);
                bus_cycles++;
                if (we) begin
                    check_store(adr, dat);
                    mem[adr[9:2]] = dat;
                end
                @(negedge clk_raw);
                wb_ack = 1'b0;
            end
        end
    end

    // 16 cycles per instruction covers gaps and ack delays
    initial begin : watchdog
        repeat (reset_cycles + prog_len * 16) @(posedge clk_raw);
        stop_run("watchdog expired before the program drained");
    end

    initial begin : main_seq
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        wb_dat_i    = '0;
        wb_ack      = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i[7:0]]     = fill_word(i);
            ref_mem[i[7:0]] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i[4:0]] = '0;
        end
        repeat (reset_cycles) @(negedge clk_raw);
        rst_n = 1'b1;
        @(negedge clk_raw);
        run_program();
        while (exp_adr.size() != 0) begin
            @(negedge clk_raw);
        end
        if (bus_cycles != mem_ops) begin
            report_mismatch("bus cycle count", isa_pkg::word_t'(mem_ops),
                            isa_pkg::word_t'(bus_cycles));
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/decode_unit.sv
rtl/register_file.sv
rtl/forwarding_unit.sv
rtl/hazard_unit.sv
rtl/alu_stage.sv
rtl/wb_data_port.sv
rtl/mips_pipeline.sv
verif/mips_pipeline_properties.sv
verif/tb_mips_pipeline.sv

//--- Makefile
# Verilator build and run for the pipeline testbench

VERILATOR  ?= verilator
TOP        ?= tb_mips_pipeline
RTL_TOP    ?= mips_pipeline
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES    := $(shell cat $(FILELIST))
RTL_FILES  := $(filter rtl/%,$(SOURCES))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) $(LINT_FLAGS) --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
